/* design/nes_ctrl_pkg.sv */
`default_nettype none

package nes_ctrl_pkg;

  // one pad, a in bit 0 up to right in bit 7
  typedef logic [7:0] pad_buttons_t;

  // full serial chain of one port, shifted out lsb first
  typedef logic [23:0] joy_chain_t;

  // multitap signature byte, sent after the tap pad
  typedef logic [7:0] tap_sig_t;

  // bits 23..8 of the chain: signature above the tap pad
  typedef logic [15:0] upper_chain_t;

  // signature seen on each port when a four player adapter is present
  localparam tap_sig_t TAP_SIG_PORT1 = 8'h08;
  localparam tap_sig_t TAP_SIG_PORT2 = 8'h04;

  // a plain pad reads back ones after its eight buttons
  localparam upper_chain_t NO_TAP_FILL = 16'hffff;

endpackage

`default_nettype wire

/* design/nes_mem_pkg.sv */
`default_nettype none

package nes_mem_pkg;

  // one byte from the download stream or the save ram
  typedef logic [7:0] byte_t;

  // colour entry, red in bits 23..16, blue in bits 7..0
  typedef logic [23:0] rgb_t;

  // 64 entry palette
  typedef logic [5:0] pal_index_t;

  // byte address of the download stream
  typedef logic [27:0] load_addr_t;

  // post download reset stretch counter
  typedef logic [7:0] stretch_cnt_t;

  // cycles left in one clearing write
  typedef logic [3:0] clear_hold_t;

  // 64 entries of three bytes
  localparam int unsigned PAL_FILE_BYTES = 192;

  // each zero write is held this long so the ram side can catch it
  localparam int unsigned CLEAR_WRITE_CYCLES = 16;

  // console stays in reset this many loader idle cycles after a download
  localparam int unsigned RESET_STRETCH = 255;

  // save ram clearer FSM
  typedef enum logic [1:0] {
    clr_idle,
    clr_write,
    clr_gap
  } clear_state_t;

endpackage

`default_nettype wire

/* design/joypad_port.sv */
`timescale 1ns/1ps
`default_nettype none

module joypad_port #(
  parameter nes_ctrl_pkg::tap_sig_t tap_signature = nes_ctrl_pkg::TAP_SIG_PORT1
) (
  input  wire                               clk_ppu_21_47,
  input  wire                               reset_nes,
  input  wire                               latch,
  input  wire                               serial_clock,
  input  wire nes_ctrl_pkg::pad_buttons_t   primary_pad,
  input  wire nes_ctrl_pkg::pad_buttons_t   alternate_pad,
  input  wire nes_ctrl_pkg::pad_buttons_t   tap_pad,
  input  wire                               multitap_enabled,
  input  wire                               swap,
  output logic                              serial_data
);

  nes_ctrl_pkg::pad_buttons_t   primary_q;
  nes_ctrl_pkg::pad_buttons_t   alternate_q;
  nes_ctrl_pkg::pad_buttons_t   tap_q;
  logic                         multitap_q;
  logic                         swap_q;

  nes_ctrl_pkg::pad_buttons_t   low_byte;
  nes_ctrl_pkg::upper_chain_t   upper_bits;
  nes_ctrl_pkg::joy_chain_t     chain;
  logic                         last_clock;
  logic                         clock_fall;

  // sample the buttons and settings once per cycle
  always_ff @(posedge clk_ppu_21_47) begin
    primary_q   <= primary_pad;
    alternate_q <= alternate_pad;
    tap_q       <= tap_pad;
    multitap_q  <= multitap_enabled;
    swap_q      <= swap;
  end

  assign low_byte = swap_q ? alternate_q : primary_q;

  // tap pad then signature, or all ones for a lone pad
  assign upper_bits = multitap_q ? {tap_signature, tap_q} : nes_ctrl_pkg::NO_TAP_FILL;

  // core drops the clock level to ask for the next bit
  assign clock_fall = last_clock & ~serial_clock;

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      chain       <= '0;
      last_clock  <= 1'b0;
      serial_data <= 1'b0;
    end else begin
      last_clock  <= serial_clock;
      serial_data <= chain[0];
      // a shift beats a load in the same cycle
      if (clock_fall) begin
        chain <= {1'b0, chain[23:1]};
      end else if (latch) begin
        chain <= {upper_bits, low_byte};
      end
    end
  end

endmodule

`default_nettype wire

/* design/palette_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module palette_loader (
  input  wire                            clk_ppu_21_47,
  input  wire                            reset_nes,
  input  wire                            palette_download,
  input  wire                            byte_strobe,
  input  wire nes_mem_pkg::load_addr_t   load_addr,
  input  wire nes_mem_pkg::byte_t        load_data,
  output logic                           pal_write,
  output nes_mem_pkg::rgb_t              pal_color,
  output nes_mem_pkg::pal_index_t        pal_index
);

  logic [1:0] pal_count;
  logic       in_range;
  logic       accept;

  assign in_range = load_addr < nes_mem_pkg::load_addr_t'(nes_mem_pkg::PAL_FILE_BYTES);
  assign accept   = palette_download & byte_strobe & in_range;

  // entry is complete whenever the next byte would be red
  assign pal_write = palette_download & (pal_count == 2'd0);

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      pal_count <= 2'd0;
      pal_index <= '0;
      pal_color <= '0;
    end else if (!palette_download) begin
      pal_count <= 2'd0;
      pal_index <= '0;
    end else if (accept) begin
      pal_count <= (pal_count == 2'd2) ? 2'd0 : pal_count + 2'd1;
      case (pal_count)
        2'd0: begin
          pal_color[23:16] <= load_data;
          // first byte of the file keeps entry 0
          if (load_addr != '0) begin
            pal_index <= pal_index + 1'b1;
          end
        end
        2'd1: begin
          pal_color[15:8] <= load_data;
        end
        default: begin
          pal_color[7:0] <= load_data;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/reset_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module reset_sequencer (
  input  wire  clk_ppu_21_47,
  input  wire  reset_nes,
  input  wire  downloading,
  input  wire  loader_busy,
  input  wire  loader_fail,
  input  wire  external_reset,
  input  wire  clearing_ram,
  output logic console_reset,
  output logic loader_reset
);

  nes_mem_pkg::stretch_cnt_t stretch_cnt;
  logic                      init_seen;
  logic                      downloading_q;
  logic                      stretch_active;

  assign stretch_active = stretch_cnt != '0;

  // keep the console quiet until a game has arrived
  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      init_seen <= 1'b0;
    end else if (downloading) begin
      init_seen <= 1'b1;
    end
  end

  // countdown only runs once the loader has gone idle
  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      stretch_cnt <= '0;
    end else if (downloading) begin
      stretch_cnt <= nes_mem_pkg::stretch_cnt_t'(nes_mem_pkg::RESET_STRETCH);
    end else if (!loader_busy && stretch_active) begin
      stretch_cnt <= stretch_cnt - 1'b1;
    end
  end

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      downloading_q <= 1'b0;
      loader_reset  <= 1'b0;
    end else begin
      downloading_q <= downloading;
      // idle loader, or a fresh download starting
      loader_reset  <= ~stretch_active | (downloading & ~downloading_q);
    end
  end

  assign console_reset = ~init_seen | stretch_active | loader_fail | external_reset |
                         clearing_ram;

endmodule

`default_nettype wire

/* design/save_ram_clearer.sv */
`timescale 1ns/1ps
`default_nettype none

module save_ram_clearer #(
  parameter int save_addr_width = 18
) (
  input  wire                          clk_ppu_21_47,
  input  wire                          reset_nes,
  input  wire                          is_downloading,
  input  wire                          palette_download,
  input  wire                          sd_buff_wr,
  input  wire                          save_busy,
  input  wire [save_addr_width-1:0]    bram_addr,
  input  wire nes_mem_pkg::byte_t      bram_dout,
  input  wire                          bram_write,
  output logic                         clearing_ram,
  output logic [save_addr_width-1:0]   ram_addr,
  output nes_mem_pkg::byte_t           ram_data,
  output logic                         ram_wren
);

  nes_mem_pkg::clear_state_t  state;
  nes_mem_pkg::clear_hold_t   hold_cnt;
  logic [save_addr_width-1:0] clear_addr;
  logic                       prev_is_downloading;
  logic                       prev_palette_download;
  logic                       did_load_save;
  logic                       start_clear;
  logic                       clear_wr;

  // start edge detection and the loaded-save flag
  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      prev_is_downloading   <= 1'b0;
      prev_palette_download <= 1'b0;
      did_load_save         <= 1'b0;
      start_clear           <= 1'b0;
    end else begin
      prev_is_downloading   <= is_downloading;
      prev_palette_download <= palette_download;
      if (sd_buff_wr) begin
        did_load_save <= 1'b1;
      end
      // assets done, nothing restored and not just a palette
      start_clear <= prev_is_downloading & ~is_downloading & ~prev_palette_download &
                     ~did_load_save;
    end
  end

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      state      <= nes_mem_pkg::clr_idle;
      hold_cnt   <= '0;
      clear_addr <= '0;
    end else begin
      case (state)
        nes_mem_pkg::clr_idle: begin
          if (start_clear) begin
            clear_addr <= '0;
            state      <= nes_mem_pkg::clr_gap;
          end
        end
        nes_mem_pkg::clr_gap: begin
          // ram side busy, so hold off the next write
          if (!save_busy) begin
            hold_cnt <= nes_mem_pkg::clear_hold_t'(nes_mem_pkg::CLEAR_WRITE_CYCLES - 1);
            state    <= nes_mem_pkg::clr_write;
          end
        end
        nes_mem_pkg::clr_write: begin
          if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
          end else if (&clear_addr) begin
            state <= nes_mem_pkg::clr_idle;
          end else begin
            clear_addr <= clear_addr + 1'b1;
            state      <= nes_mem_pkg::clr_gap;
          end
        end
        default: begin
          state <= nes_mem_pkg::clr_idle;
        end
      endcase
    end
  end

  assign clearing_ram = state != nes_mem_pkg::clr_idle;
  assign clear_wr     = state == nes_mem_pkg::clr_write;

  // clearer owns the port while it runs
  assign ram_addr = clearing_ram ? clear_addr : bram_addr;
  assign ram_data = clearing_ram ? nes_mem_pkg::byte_t'(0) : bram_dout;
  assign ram_wren = clearing_ram ? clear_wr : bram_write;

endmodule

`default_nettype wire

/* design/nes_glue_top.sv */
`timescale 1ns/1ps
`default_nettype none

module nes_glue_top #(
  parameter int save_addr_width = 18
) (
  input  wire                              clk_ppu_21_47,
  input  wire                              reset_nes,
  input  wire nes_ctrl_pkg::pad_buttons_t  p1_pad,
  input  wire nes_ctrl_pkg::pad_buttons_t  p2_pad,
  input  wire nes_ctrl_pkg::pad_buttons_t  p3_pad,
  input  wire nes_ctrl_pkg::pad_buttons_t  p4_pad,
  input  wire                              multitap_enabled,
  input  wire                              swap_controllers,
  input  wire                              joypad_latch,
  input  wire [1:0]                        joypad_clock,
  input  wire                              downloading,
  input  wire                              loader_busy,
  input  wire                              loader_fail,
  input  wire                              external_reset,
  input  wire                              palette_download,
  input  wire                              ioctl_wr,
  input  wire nes_mem_pkg::load_addr_t     ioctl_addr,
  input  wire nes_mem_pkg::byte_t          ioctl_dout,
  input  wire                              is_downloading,
  input  wire                              sd_buff_wr,
  input  wire                              save_busy,
  input  wire [save_addr_width-1:0]        bram_addr,
  input  wire nes_mem_pkg::byte_t          bram_dout,
  input  wire                              bram_write,
  output wire                              joypad1_data,
  output wire                              joypad2_data,
  output wire                              pal_write,
  output wire nes_mem_pkg::rgb_t           pal_color,
  output wire nes_mem_pkg::pal_index_t     pal_index,
  output wire                              console_reset,
  output wire                              loader_reset,
  output wire                              clearing_ram,
  output wire [save_addr_width-1:0]        ram_addr,
  output wire nes_mem_pkg::byte_t          ram_data,
  output wire                              ram_wren
);

  // port 1 swaps in p2, taps p3
  joypad_port #(
    .tap_signature (nes_ctrl_pkg::TAP_SIG_PORT1)
  ) port1 (
    .clk_ppu_21_47    (clk_ppu_21_47),
    .reset_nes        (reset_nes),
    .latch            (joypad_latch),
    .serial_clock     (joypad_clock[0]),
    .primary_pad      (p1_pad),
    .alternate_pad    (p2_pad),
    .tap_pad          (p3_pad),
    .multitap_enabled (multitap_enabled),
    .swap             (swap_controllers),
    .serial_data      (joypad1_data)
  );

  // port 2 swaps in p1, taps p4
  joypad_port #(
    .tap_signature (nes_ctrl_pkg::TAP_SIG_PORT2)
  ) port2 (
    .clk_ppu_21_47    (clk_ppu_21_47),
    .reset_nes        (reset_nes),
    .latch            (joypad_latch),
    .serial_clock     (joypad_clock[1]),
    .primary_pad      (p2_pad),
    .alternate_pad    (p1_pad),
    .tap_pad          (p4_pad),
    .multitap_enabled (multitap_enabled),
    .swap             (swap_controllers),
    .serial_data      (joypad2_data)
  );

  palette_loader pal_loader (
    .clk_ppu_21_47    (clk_ppu_21_47),
    .reset_nes        (reset_nes),
    .palette_download (palette_download),
    .byte_strobe      (ioctl_wr),
    .load_addr        (ioctl_addr),
    .load_data        (ioctl_dout),
    .pal_write        (pal_write),
    .pal_color        (pal_color),
    .pal_index        (pal_index)
  );

  reset_sequencer rst_seq (
    .clk_ppu_21_47  (clk_ppu_21_47),
    .reset_nes      (reset_nes),
    .downloading    (downloading),
    .loader_busy    (loader_busy),
    .loader_fail    (loader_fail),
    .external_reset (external_reset),
    .clearing_ram   (clearing_ram),
    .console_reset  (console_reset),
    .loader_reset   (loader_reset)
  );

  save_ram_clearer #(
    .save_addr_width (save_addr_width)
  ) ram_clear (
    .clk_ppu_21_47    (clk_ppu_21_47),
    .reset_nes        (reset_nes),
    .is_downloading   (is_downloading),
    .palette_download (palette_download),
    .sd_buff_wr       (sd_buff_wr),
    .save_busy        (save_busy),
    .bram_addr        (bram_addr),
    .bram_dout        (bram_dout),
    .bram_write       (bram_write),
    .clearing_ram     (clearing_ram),
    .ram_addr         (ram_addr),
    .ram_data         (ram_data),
    .ram_wren         (ram_wren)
  );

endmodule

`default_nettype wire

/* verif/nes_glue_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module nes_glue_asserts (
  input wire                     clk_ppu_21_47,
  input wire                     reset_nes,
  input wire                     clearing_ram,
  input wire                     ram_wren,
  input wire nes_mem_pkg::byte_t ram_data,
  input wire                     save_busy,
  input wire                     external_reset,
  input wire                     console_reset
);

  // failed checks in this instance
  int unsigned error_count = 0;

  // each zero write lasts exactly the hold time
  write_length: assert property (@(posedge clk_ppu_21_47) disable iff (reset_nes)
    $rose(ram_wren) && clearing_ram |->
      ram_wren [*nes_mem_pkg::CLEAR_WRITE_CYCLES] ##1 !ram_wren)
  else begin
    error_count++;
    $error("clearing write not held for the full hold time");
  end

  clear_data_zero: assert property (@(posedge clk_ppu_21_47) disable iff (reset_nes)
    clearing_ram |-> ram_data == '0)
  else begin
    error_count++;
    $error("nonzero save ram data while clearing");
  end

  // a write only starts after save_busy was seen low
  write_not_busy: assert property (@(posedge clk_ppu_21_47) disable iff (reset_nes)
    $rose(ram_wren) && clearing_ram |-> !$past(save_busy))
  else begin
    error_count++;
    $error("clearing write started while save ram was busy");
  end

  ext_reset_holds: assert property (@(posedge clk_ppu_21_47) disable iff (reset_nes)
    external_reset |-> console_reset)
  else begin
    error_count++;
    $error("console_reset low during external reset");
  end

endmodule

// clearer side, reset causes tied off
bind save_ram_clearer nes_glue_asserts clear_checks (
  .clk_ppu_21_47  (clk_ppu_21_47),
  .reset_nes      (reset_nes),
  .clearing_ram   (clearing_ram),
  .ram_wren       (ram_wren),
  .ram_data       (ram_data),
  .save_busy      (save_busy),
  .external_reset (1'b0),
  .console_reset  (1'b1)
);

// sequencer side, ram port tied off
bind reset_sequencer nes_glue_asserts reset_checks (
  .clk_ppu_21_47  (clk_ppu_21_47),
  .reset_nes      (reset_nes),
  .clearing_ram   (clearing_ram),
  .ram_wren       (1'b0),
  .ram_data       (8'h00),
  .save_busy      (1'b0),
  .external_reset (external_reset),
  .console_reset  (console_reset)
);

`default_nettype wire

/* verif/tb_nes_glue.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_nes_glue;

  localparam int SAVE_ADDR_WIDTH = 6;
  localparam int MAX_TESTS = 64;
  localparam int WAIT_LIMIT = 400;

  logic                        clk_ppu_21_47;
  logic                        reset_nes;
  nes_ctrl_pkg::pad_buttons_t  p1_pad;
  nes_ctrl_pkg::pad_buttons_t  p2_pad;
  nes_ctrl_pkg::pad_buttons_t  p3_pad;
  nes_ctrl_pkg::pad_buttons_t  p4_pad;
  logic                        multitap_enabled;
  logic                        swap_controllers;
  logic                        joypad_latch;
  logic [1:0]                  joypad_clock;
  logic                        downloading;
  logic                        loader_busy;
  logic                        loader_fail;
  logic                        external_reset;
  logic                        palette_download;
  logic                        ioctl_wr;
  nes_mem_pkg::load_addr_t     ioctl_addr;
  nes_mem_pkg::byte_t          ioctl_dout;
  logic                        is_downloading;
  logic                        sd_buff_wr;
  logic                        save_busy;
  logic [SAVE_ADDR_WIDTH-1:0]  bram_addr;
  nes_mem_pkg::byte_t          bram_dout;
  logic                        bram_write;
  logic                        joypad1_data;
  logic                        joypad2_data;
  logic                        pal_write;
  nes_mem_pkg::rgb_t           pal_color;
  nes_mem_pkg::pal_index_t     pal_index;
  logic                        console_reset;
  logic                        loader_reset;
  logic                        clearing_ram;
  logic [SAVE_ADDR_WIDTH-1:0]  ram_addr;
  nes_mem_pkg::byte_t          ram_data;
  logic                        ram_wren;

  // op, flags, then fields a, b, c and d
  logic [127:0] tests [0:MAX_TESTS-1];
  logic [127:0] rec;
  int           idx;
  int unsigned  assert_errors;

  nes_glue_top #(
    .save_addr_width (SAVE_ADDR_WIDTH)
  ) DUT (.*);

  initial begin
    clk_ppu_21_47 = 1'b0;
    forever #20 clk_ppu_21_47 = ~clk_ppu_21_47;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      abort_run($sformatf("** Error: %s = 0x%0h, expected 0x%0h", name, actual, expected));
    end
  endtask

  task automatic check_rgb(input string name, input nes_mem_pkg::rgb_t actual,
                           input nes_mem_pkg::rgb_t expected);
    if (actual !== expected) begin
      abort_run($sformatf("** Error: %s = 0x%0h, expected 0x%0h", name, actual, expected));
    end
  endtask

  task automatic check_index(input string name, input nes_mem_pkg::pal_index_t actual,
                             input nes_mem_pkg::pal_index_t expected);
    if (actual !== expected) begin
      abort_run($sformatf("** Error: %s = 0x%0h, expected 0x%0h", name, actual, expected));
    end
  endtask

  task automatic check_ram_addr(input string name, input logic [SAVE_ADDR_WIDTH-1:0] actual,
                                input logic [SAVE_ADDR_WIDTH-1:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("** Error: %s = 0x%0h, expected 0x%0h", name, actual, expected));
    end
  endtask

  task automatic check_byte(input string name, input nes_mem_pkg::byte_t actual,
                            input nes_mem_pkg::byte_t expected);
    if (actual !== expected) begin
      abort_run($sformatf("** Error: %s = 0x%0h, expected 0x%0h", name, actual, expected));
    end
  endtask

  task automatic idle_gap();
    int n;
    n = $urandom_range(3, 0);
    repeat (n) @(negedge clk_ppu_21_47);
  endtask

  task automatic wait_wren(input logic level);
    int cycles;
    cycles = 0;
    while (ram_wren !== level) begin
      @(negedge clk_ppu_21_47);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        abort_run($sformatf("timed out waiting for ram_wren to become %0d", level));
      end
    end
  endtask

  task automatic wait_clearing(input logic level);
    int cycles;
    cycles = 0;
    while (clearing_ram !== level) begin
      @(negedge clk_ppu_21_47);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        abort_run($sformatf("timed out waiting for clearing_ram to become %0d", level));
      end
    end
  endtask

  // latch, then one serial clock pulse per further bit on both ports
  task automatic shift_joypads(input logic [7:0] flags, input logic [31:0] pads,
                               input logic [31:0] exp1, input logic [31:0] exp2);
    int k;
    {p4_pad, p3_pad, p2_pad, p1_pad} = pads;
    multitap_enabled = flags[0];
    swap_controllers = flags[1];
    @(negedge clk_ppu_21_47);
    joypad_latch = 1'b1;
    @(negedge clk_ppu_21_47);
    joypad_latch = 1'b0;
    @(negedge clk_ppu_21_47);
    check_bit("joypad1_data bit 0", joypad1_data, exp1[0]);
    check_bit("joypad2_data bit 0", joypad2_data, exp2[0]);
    for (k = 1; k < 32; k++) begin
      joypad_clock = 2'b11;
      @(negedge clk_ppu_21_47);
      joypad_clock = 2'b00;
      // shift on one edge, registered output on the next
      repeat (2) @(negedge clk_ppu_21_47);
      check_bit($sformatf("joypad1_data bit %0d", k), joypad1_data, exp1[k]);
      check_bit($sformatf("joypad2_data bit %0d", k), joypad2_data, exp2[k]);
    end
  endtask

  task automatic load_palette(input logic [7:0] count, input logic [31:0] addr,
                              input logic [31:0] bytes, input logic [31:0] exp_color,
                              input logic [15:0] exp_index);
    int k;
    palette_download = 1'b1;
    for (k = 0; k < count; k++) begin
      ioctl_wr   = 1'b1;
      ioctl_addr = nes_mem_pkg::load_addr_t'(addr + k);
      ioctl_dout = bytes[23 - 8*k -: 8];
      @(negedge clk_ppu_21_47);
    end
    ioctl_wr = 1'b0;
    check_rgb("pal_color", pal_color, exp_color[23:0]);
    check_index("pal_index", pal_index, exp_index[5:0]);
    check_bit("pal_write", pal_write, 1'b1);
  endtask

  task automatic end_palette(input logic exp_write);
    palette_download = 1'b0;
    @(negedge clk_ppu_21_47);
    check_bit("pal_write", pal_write, exp_write);
  endtask

  // count idle cycles until the stretched reset lets go
  task automatic finish_download(input int hold, input int min_cycles, input int max_cycles);
    int cycles;
    loader_busy = 1'b0;
    // stretch counter idle, so the loader is held in reset
    check_bit("loader_reset", loader_reset, 1'b1);
    downloading = 1'b1;
    repeat (hold) @(negedge clk_ppu_21_47);
    // counter loaded and past the first download cycle
    check_bit("loader_reset", loader_reset, hold < 2);
    downloading = 1'b0;
    cycles = 0;
    while (console_reset !== 1'b0) begin
      @(negedge clk_ppu_21_47);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        abort_run("console_reset never fell after the download ended");
      end
    end
    if (cycles < min_cycles || cycles > max_cycles) begin
      abort_run($sformatf("console_reset fell %0d cycles after the download, allowed %0d to %0d",
                          cycles, min_cycles, max_cycles));
    end
    // loader reset follows the empty counter one cycle later
    check_bit("loader_reset", loader_reset, 1'b0);
    @(negedge clk_ppu_21_47);
    check_bit("loader_reset", loader_reset, 1'b1);
  endtask

  task automatic apply_reset_causes(input logic [7:0] flags, input logic exp_reset);
    external_reset = flags[0];
    loader_fail    = flags[1];
    @(negedge clk_ppu_21_47);
    check_bit("console_reset", console_reset, exp_reset);
  endtask

  task automatic clear_save_ram(input logic [7:0] flags, input logic [63:0] busy_mask,
                                input int last_addr, input int busy_cycles);
    int k;
    int i;
    is_downloading = 1'b1;
    repeat (2) @(negedge clk_ppu_21_47);
    is_downloading = 1'b0;
    wait_clearing(1'b1);
    for (k = 0; k <= last_addr; k++) begin
      // busy ram side must hold the next write back
      if (busy_mask[k]) begin
        save_busy = 1'b1;
        for (i = 0; i < busy_cycles; i++) begin
          @(negedge clk_ppu_21_47);
          check_bit("ram_wren", ram_wren, 1'b0);
        end
        save_busy = 1'b0;
      end
      wait_wren(1'b1);
      check_ram_addr("ram_addr", ram_addr, SAVE_ADDR_WIDTH'(k));
      check_byte("ram_data", ram_data, 8'h00);
      check_bit("console_reset", console_reset, 1'b1);
      wait_wren(1'b0);
    end
    check_bit("clearing_ram", clearing_ram, 1'b0);
    check_bit("console_reset", console_reset, flags[0]);
  endtask

  task automatic expect_no_clear(input logic [7:0] flags, input int watch);
    int k;
    if (flags[0]) begin
      sd_buff_wr = 1'b1;
      @(negedge clk_ppu_21_47);
      sd_buff_wr = 1'b0;
    end
    palette_download = flags[1];
    is_downloading   = 1'b1;
    repeat (2) @(negedge clk_ppu_21_47);
    is_downloading   = 1'b0;
    palette_download = 1'b0;
    for (k = 0; k < watch; k++) begin
      @(negedge clk_ppu_21_47);
      check_bit("clearing_ram", clearing_ram, 1'b0);
    end
  endtask

  task automatic drive_bram(input logic [7:0] flags, input logic [31:0] addr,
                            input logic [31:0] data);
    bram_addr  = addr[SAVE_ADDR_WIDTH-1:0];
    bram_dout  = data[7:0];
    bram_write = flags[0];
    @(negedge clk_ppu_21_47);
    check_ram_addr("ram_addr", ram_addr, addr[SAVE_ADDR_WIDTH-1:0]);
    check_byte("ram_data", ram_data, data[7:0]);
    check_bit("ram_wren", ram_wren, flags[0]);
    bram_write = 1'b0;
  endtask

  initial begin
    void'($urandom(32'h40bf8415));
    reset_nes        = 1'b1;
    p1_pad           = '0;
    p2_pad           = '0;
    p3_pad           = '0;
    p4_pad           = '0;
    multitap_enabled = 1'b0;
    swap_controllers = 1'b0;
    joypad_latch     = 1'b0;
    joypad_clock     = 2'b00;
    downloading      = 1'b0;
    loader_busy      = 1'b0;
    loader_fail      = 1'b0;
    external_reset   = 1'b0;
    palette_download = 1'b0;
    ioctl_wr         = 1'b0;
    ioctl_addr       = '0;
    ioctl_dout       = '0;
    is_downloading   = 1'b0;
    sd_buff_wr       = 1'b0;
    save_busy        = 1'b0;
    bram_addr        = '0;
    bram_dout        = '0;
    bram_write       = 1'b0;
    $readmemh("verif/nes_glue_tests.txt", tests);
    repeat (8) @(negedge clk_ppu_21_47);
    reset_nes = 1'b0;
    idx = 0;
    while (idx < MAX_TESTS && tests[idx][127:120] !== 8'hff) begin
      rec = tests[idx];
      idle_gap();
      case (rec[127:120])
        8'h01: shift_joypads(rec[119:112], rec[111:80], rec[79:48], rec[47:16]);
        8'h02: load_palette(rec[119:112], rec[111:80], rec[79:48], rec[47:16], rec[15:0]);
        8'h03: finish_download(rec[111:80], rec[79:48], rec[47:16]);
        8'h04: apply_reset_causes(rec[119:112], rec[16]);
        8'h05: clear_save_ram(rec[119:112], rec[111:48], rec[47:16], rec[15:0]);
        8'h06: expect_no_clear(rec[119:112], rec[111:80]);
        8'h07: drive_bram(rec[119:112], rec[111:80], rec[79:48]);
        8'h08: end_palette(rec[16]);
        default: abort_run($sformatf("bad operation in test record %0d", idx));
      endcase
      idx++;
    end
    assert_errors = DUT.ram_clear.clear_checks.error_count +
                    DUT.rst_seq.reset_checks.error_count;
    if (idx == MAX_TESTS || assert_errors != 0) begin
      abort_run($sformatf("%0d assertion failures, or no end record in the test file",
                          assert_errors));
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* verif/nes_glue_tests.txt */
// op_flags_a_b_c_d in hex, one operation per line, ff ends the list
// 01 pads: fl {swap,tap} a {p4,p3,p2,p1} b/c port 1/2 bits lsb first
// 02 palette: fl bytes, a addr, b bytes red first, c colour, d index
// 03 download: a cycles, b..c window for console_reset release
// 04 reset causes: fl {fail,external}, c console_reset
// 05 clear: a:b busy mask per write, c last addr, d busy cycles, fl console_reset after
// 06 no clear: fl {palette,sd write}, a cycles watched
// 07 bram pass-through: fl bram_write, a addr, b data
// 08 palette off: c pal_write
04_00_00000000_00000000_00000001_0000
01_00_7e813ca5_00ffffa5_00ffff3c_0000
01_03_7e813ca5_0008813c_00047ea5_0000
02_03_00000000_00123456_00123456_0000
02_03_00000003_00abcdef_00abcdef_0001
02_03_00000006_00fe0180_00fe0180_0002
02_01_000000c0_00990000_00fe0180_0002
08_00_00000000_00000000_00000000_0000
03_00_00000004_000000ff_00000101_0000
04_01_00000000_00000000_00000001_0000
04_02_00000000_00000000_00000001_0000
04_00_00000000_00000000_00000000_0000
05_00_80000000_00000401_0000003f_0005
06_02_00000008_00000000_00000000_0000
06_01_00000008_00000000_00000000_0000
07_01_0000002a_0000005a_00000000_0000
07_00_00000015_000000c3_00000000_0000
ff_00_00000000_00000000_00000000_0000

/* build.f */
design/nes_ctrl_pkg.sv
design/nes_mem_pkg.sv
design/joypad_port.sv
design/palette_loader.sv
design/reset_sequencer.sv
design/save_ram_clearer.sv
design/nes_glue_top.sv
verif/nes_glue_asserts.sv
verif/tb_nes_glue.sv
